// ==== mem_wb_backend.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/data_memory.sv
source/memory_access_stage.sv
source/write_back_stage.sv
source/register_file.sv
source/mem_wb_backend.sv
tests/mem_wb_backend_asserts.sv
tests/mem_wb_backend_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ns \
    --top-module mem_wb_backend_tb \
    -f mem_wb_backend.f \
    -o mem_wb_backend_sim

./obj_dir/mem_wb_backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== source/data_memory.sv ====
module data_memory
    import isa_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  logic                         wb_clk,
    input  logic                         wb_rst,
    input  logic [$clog2(mem_words)-1:0] addr,
    input  logic [xlen-1:0]              wdata,
    input  logic [byte_lanes-1:0]        byte_en,
    input  logic                         we,
    input  logic                         re,
    output logic [xlen-1:0]              rdata
);

    logic [xlen-1:0] mem [mem_words];

    // Per-lane write
    always_ff @(posedge wb_clk) begin
        if (we) begin
            for (int i = 0; i < byte_lanes; i++) begin
                if (byte_en[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Read register keeps its word while re is low
    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            rdata <= '0;
        end
        else if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    // Datapath and PC width
    localparam int xlen = 32;

    localparam int reg_addr_width = 5;
    localparam int reg_count = 2 ** reg_addr_width;

    localparam int funct3_width = 3;

    // Width of the one-hot opcode word
    localparam int opcode_width = 11;

    // One-hot opcode bit positions
    localparam int rtype = 0;
    localparam int itype = 1;
    localparam int load = 2;
    localparam int store = 3;
    localparam int branch = 4;
    localparam int jal = 5;
    localparam int jalr = 6;
    localparam int lui = 7;
    localparam int auipc = 8;
    localparam int system = 9;
    localparam int fence = 10;

    // Load and store funct3
    localparam logic [funct3_width-1:0] f3_byte = 3'b000;
    localparam logic [funct3_width-1:0] f3_half = 3'b001;
    localparam logic [funct3_width-1:0] f3_word = 3'b010;
    localparam logic [funct3_width-1:0] f3_byte_u = 3'b100;
    localparam logic [funct3_width-1:0] f3_half_u = 3'b101;

    // Byte lanes in one word
    localparam int byte_lanes = xlen / 8;

endpackage

// ==== source/mem_wb_backend.sv ====
module mem_wb_backend
    import isa_pkg::*, pipe_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  logic                      wb_clk,
    input  logic                      wb_rst,
    input  ex_mem_t                   ex_in,
    input  logic                      stall,
    input  logic                      flush,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    output rd_write_t                 rd_write,
    output logic                      retire_ce,
    output logic [xlen-1:0]           next_pc,
    output logic                      change_pc,
    output logic                      flush_out,
    output logic [xlen-1:0]           rs1_data,
    output logic [xlen-1:0]           rs2_data
);

    mem_wb_t mem_wb;

    memory_access_stage #(
        .mem_words(mem_words)
    ) mem0 (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .stall(stall),
        .flush(flush),
        .ex_in(ex_in),
        .mem_out(mem_wb)
    );

    write_back_stage wb0 (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .stall(stall),
        .flush(flush),
        .mem_in(mem_wb),
        .rd_write(rd_write),
        .retire_ce(retire_ce),
        .next_pc(next_pc),
        .change_pc(change_pc),
        .flush_out(flush_out)
    );

    register_file rf0 (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .wr(rd_write),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

endmodule

// ==== source/memory_access_stage.sv ====
module memory_access_stage
    import isa_pkg::*, pipe_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  logic    wb_clk,
    input  logic    wb_rst,
    input  logic    stall,
    input  logic    flush,
    input  ex_mem_t ex_in,
    output mem_wb_t mem_out
);

    localparam int addr_width = $clog2(mem_words);

    logic                  advance;
    logic                  op_load;
    logic                  op_store;
    logic [1:0]            offset;
    logic [addr_width-1:0] dmem_addr;
    logic [xlen-1:0]       st_wdata;
    logic [byte_lanes-1:0] st_byte_en;
    logic                  dmem_we;
    logic                  dmem_re;
    logic [xlen-1:0]       dmem_rdata;
    mem_wb_t               stage_q;
    logic [1:0]            ld_offset;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    logic [xlen-1:0]       load_ext;

    assign advance = ex_in.ce && !flush && !stall;
    assign op_load = ex_in.opcode[load];
    assign op_store = ex_in.opcode[store];
    assign offset = ex_in.alu_result[1:0];
    assign dmem_addr = ex_in.alu_result[addr_width+1:2];

    // Shift store data into its lanes
    always_comb begin
        case (ex_in.funct)
            f3_byte: begin
                st_wdata = ex_in.store_data << {offset, 3'b000};
                st_byte_en = 4'b0001 << offset;
            end
            f3_half: begin
                st_wdata = ex_in.store_data << {offset[1], 4'b0000};
                st_byte_en = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                st_wdata = ex_in.store_data;
                st_byte_en = 4'b1111;
            end
        endcase
    end

    assign dmem_we = advance && op_store;
    assign dmem_re = advance && op_load;

    data_memory #(
        .mem_words(mem_words)
    ) dmem0 (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .addr(dmem_addr),
        .wdata(st_wdata),
        .byte_en(st_byte_en),
        .we(dmem_we),
        .re(dmem_re),
        .rdata(dmem_rdata)
    );

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            stage_q <= '0;
        end
        else if (flush) begin
            stage_q.ce <= 1'b0;
            stage_q.we_rd <= 1'b0;
            stage_q.rd_addr <= '0;
        end
        else if (advance) begin
            stage_q.ce <= 1'b1;
            stage_q.opcode <= ex_in.opcode;
            stage_q.funct <= ex_in.funct;
            stage_q.we_rd <= ex_in.we_rd;
            stage_q.rd_addr <= ex_in.rd_addr;
            stage_q.alu_result <= ex_in.alu_result;
            stage_q.pc <= ex_in.pc;
            stage_q.change_pc <= ex_in.change_pc;
        end
        else if (!stall) begin
            // Bubble
            stage_q.ce <= 1'b0;
            stage_q.we_rd <= 1'b0;
        end
    end

    // Byte offset of the registered load
    assign ld_offset = stage_q.alu_result[1:0];
    assign ld_byte = dmem_rdata[{ld_offset, 3'b000} +: 8];
    assign ld_half = dmem_rdata[{ld_offset[1], 4'b0000} +: 16];

    always_comb begin
        case (stage_q.funct)
            f3_byte:   load_ext = {{(xlen-8){ld_byte[7]}}, ld_byte};
            f3_half:   load_ext = {{(xlen-16){ld_half[15]}}, ld_half};
            f3_byte_u: load_ext = {{(xlen-8){1'b0}}, ld_byte};
            f3_half_u: load_ext = {{(xlen-16){1'b0}}, ld_half};
            default:   load_ext = dmem_rdata;
        endcase
    end

    always_comb begin
        mem_out = stage_q;
        mem_out.load_data = load_ext;
    end

endmodule

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // Execute to memory bundle
    typedef struct packed {
        logic                      ce;
        logic [opcode_width-1:0]   opcode;
        logic [funct3_width-1:0]   funct;
        logic                      we_rd;
        logic [reg_addr_width-1:0] rd_addr;
        // Address for loads and stores, result otherwise
        logic [xlen-1:0]           alu_result;
        logic [xlen-1:0]           store_data;
        logic [xlen-1:0]           pc;
        logic                      change_pc;
    } ex_mem_t;

    // Memory to write-back bundle
    typedef struct packed {
        logic                      ce;
        logic [opcode_width-1:0]   opcode;
        logic [funct3_width-1:0]   funct;
        logic                      we_rd;
        logic [reg_addr_width-1:0] rd_addr;
        logic [xlen-1:0]           alu_result;
        // Already aligned and extended
        logic [xlen-1:0]           load_data;
        logic [xlen-1:0]           pc;
        logic                      change_pc;
    } mem_wb_t;

    // Retired register write
    typedef struct packed {
        logic                      we;
        logic [reg_addr_width-1:0] addr;
        logic [xlen-1:0]           data;
    } rd_write_t;

endpackage

// ==== source/register_file.sv ====
module register_file
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                      wb_clk,
    input  logic                      wb_rst,
    input  rd_write_t                 wr,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    output logic [xlen-1:0]           rs1_data,
    output logic [xlen-1:0]           rs2_data
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end
        // x0 is never written
        else if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== source/write_back_stage.sv ====
module write_back_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic            wb_clk,
    input  logic            wb_rst,
    input  logic            stall,
    input  logic            flush,
    input  mem_wb_t         mem_in,
    output rd_write_t       rd_write,
    output logic            retire_ce,
    output logic [xlen-1:0] next_pc,
    output logic            change_pc,
    output logic            flush_out
);

    logic            advance;
    logic            op_alu;
    logic [xlen-1:0] retire_data;

    assign advance = mem_in.ce && !stall;

    // Instructions that retire the ALU result
    assign op_alu = mem_in.opcode[rtype] || mem_in.opcode[itype] ||
                    mem_in.opcode[jal] || mem_in.opcode[jalr] ||
                    mem_in.opcode[lui] || mem_in.opcode[auipc];

    always_comb begin
        if (mem_in.opcode[load]) begin
            retire_data = mem_in.load_data;
        end
        else if (op_alu) begin
            retire_data = mem_in.alu_result;
        end
        else begin
            retire_data = '0;
        end
    end

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            retire_ce <= 1'b0;
            rd_write <= '0;
            next_pc <= '0;
            change_pc <= 1'b0;
            flush_out <= 1'b0;
        end
        else begin
            // One cycle behind the flush input
            flush_out <= flush;
            if (flush) begin
                retire_ce <= 1'b0;
                rd_write.we <= 1'b0;
                rd_write.addr <= '0;
                rd_write.data <= '0;
                change_pc <= 1'b0;
            end
            else if (advance) begin
                retire_ce <= 1'b1;
                rd_write.we <= mem_in.we_rd;
                rd_write.addr <= mem_in.rd_addr;
                rd_write.data <= retire_data;
                next_pc <= mem_in.pc + xlen'(4);
                change_pc <= mem_in.change_pc;
            end
            else if (stall) begin
                rd_write.data <= '0;
            end
            else begin
                // Nothing arriving from the memory stage
                retire_ce <= 1'b0;
                rd_write.we <= 1'b0;
                rd_write.data <= '0;
                change_pc <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/mem_wb_backend_asserts.sv ====
module mem_wb_backend_asserts
    import isa_pkg::*, pipe_pkg::*;
(
    input logic                      wb_clk,
    input logic                      wb_rst,
    input logic                      flush,
    input logic                      flush_out,
    input logic                      retire_ce,
    input rd_write_t                 rd_write,
    input logic [reg_addr_width-1:0] rs1_addr,
    input logic [xlen-1:0]           rs1_data
);

    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed assertions
    int failures = 0;

    // flush_out trails flush by exactly one cycle
    flush_delay: assert property (
        @(posedge wb_clk) disable iff (!wb_rst) ##1 (flush_out == $past(flush))
    ) else begin
        $error("flush_out does not follow flush by one cycle");
        failures++;
    end

    no_retire_after_flush: assert property (
        @(posedge wb_clk) disable iff (!wb_rst) flush |=> !retire_ce
    ) else begin
        $error("retire_ce high in the cycle after a flush");
        failures++;
    end

    // A write to x0 must leave it reading zero
    x0_stays_zero: assert property (
        @(posedge wb_clk) disable iff (!wb_rst)
        (rd_write.we && rd_write.addr == '0) |=> (rs1_addr != '0 || rs1_data == '0)
    ) else begin
        $error("x0 reads nonzero after a write to x0");
        failures++;
    end

endmodule

bind mem_wb_backend mem_wb_backend_asserts asserts0 (
    .wb_clk(wb_clk),
    .wb_rst(wb_rst),
    .flush(flush),
    .flush_out(flush_out),
    .retire_ce(retire_ce),
    .rd_write(rd_write),
    .rs1_addr(rs1_addr),
    .rs1_data(rs1_data)
);

// ==== tests/mem_wb_backend_tb.sv ====
module mem_wb_backend_tb
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 100;
    localparam int mem_words = 256;
    // Cycle budget per test
    localparam int reset_cycles = 4;
    localparam int alu_cycles = 7 * 3;
    localparam int mem_cycles = 12 + 4 * 13 * 2;
    localparam int pc_cycles = 3 * 2;
    localparam int stall_cycles = 16;
    localparam int flush_cycles = 10;
    localparam int margin_cycles = 50;
    localparam int watchdog_cycles = reset_cycles + alu_cycles + mem_cycles + pc_cycles +
                                     stall_cycles + flush_cycles + margin_cycles;

    logic                      wb_clk;
    logic                      wb_rst;
    ex_mem_t                   ex_in;
    logic                      stall;
    logic                      flush;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    rd_write_t                 rd_write;
    logic                      retire_ce;
    logic [xlen-1:0]           next_pc;
    logic                      change_pc;
    logic                      flush_out;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;

    int          errors;
    int          checks;
    logic [31:0] rng_state;
    // Expected contents of the low data memory words
    logic [31:0] shadow [64];

    mem_wb_backend #(
        .mem_words(mem_words)
    ) dut0 (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .ex_in(ex_in),
        .stall(stall),
        .flush(flush),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_write(rd_write),
        .retire_ce(retire_ce),
        .next_pc(next_pc),
        .change_pc(change_pc),
        .flush_out(flush_out),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    always #(clk_period / 2) wb_clk = ~wb_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic ex_mem_t make_instr(input int op, input logic [2:0] f3, input logic we,
                                           input logic [4:0] rd, input logic [31:0] alu,
                                           input logic [31:0] sdata, input logic [31:0] pc,
                                           input logic chg);
        ex_mem_t i;
        i = '0;
        i.ce = 1'b1;
        i.opcode[op] = 1'b1;
        i.funct = f3;
        i.we_rd = we;
        i.rd_addr = rd;
        i.alu_result = alu;
        i.store_data = sdata;
        i.pc = pc;
        i.change_pc = chg;
        return i;
    endfunction

    // Lane selection and extension of a load
    function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[addr[7:2]];
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (f3)
            f3_byte:   return {{24{b[7]}}, b};
            f3_half:   return {{16{h[15]}}, h};
            f3_byte_u: return {24'd0, b};
            f3_half_u: return {16'd0, h};
            default:   return w;
        endcase
    endfunction

    task automatic step_clock();
        @(posedge wb_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_retire(input logic we, input logic [4:0] addr, input logic [31:0] data,
                                input logic [31:0] npc, input logic chg);
        check_value("retire_ce", 32'(retire_ce), 32'd1);
        check_value("rd_write.we", 32'(rd_write.we), 32'(we));
        check_value("rd_write.addr", 32'(rd_write.addr), 32'(addr));
        check_value("rd_write.data", rd_write.data, data);
        check_value("next_pc", next_pc, npc);
        check_value("change_pc", 32'(change_pc), 32'(chg));
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] exp);
        rs1_addr = addr;
        rs2_addr = addr;
        #10;
        check_value("rs1_data", rs1_data, exp);
        check_value("rs2_data", rs2_data, exp);
    endtask

    // One instruction, then an idle execute stage
    task automatic issue(input ex_mem_t i);
        ex_in = i;
        step_clock();
        ex_in = '0;
    endtask

    task automatic store_to(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] data);
        issue(make_instr(store, f3, 1'b0, 5'd0, addr, data, 32'd0, 1'b0));
        case (f3)
            f3_byte: shadow[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
            f3_half: shadow[addr[7:2]][16*addr[1] +: 16] = data[15:0];
            default: shadow[addr[7:2]] = data;
        endcase
    endtask

    task automatic load_check(input logic [2:0] f3, input logic [31:0] addr,
                              input logic [4:0] rd);
        logic [31:0] pc;
        logic [31:0] exp;
        pc = next_rand() & 32'hffff_fffc;
        exp = expect_load(f3, addr);
        issue(make_instr(load, f3, 1'b1, rd, addr, 32'd0, pc, 1'b0));
        step_clock();
        check_retire(1'b1, rd, exp, pc + 32'd4, 1'b0);
    endtask

    task automatic alu_retire_test();
        int          ops [6];
        logic [31:0] data;
        logic [31:0] pc;
        logic [4:0]  rd;
        ops = '{rtype, itype, lui, auipc, jal, jalr};
        for (int k = 0; k < 6; k++) begin
            rd = 5'(k + 1);
            data = next_rand();
            pc = next_rand() & 32'hffff_fffc;
            issue(make_instr(ops[k], f3_word, 1'b1, rd, data, 32'd0, pc, pc[2]));
            step_clock();
            check_retire(1'b1, rd, data, pc + 32'd4, pc[2]);
            step_clock();
            check_reg(rd, data);
        end
        data = next_rand() | 32'd1;
        pc = next_rand() & 32'hffff_fffc;
        issue(make_instr(itype, f3_word, 1'b1, 5'd0, data, 32'd0, pc, 1'b0));
        step_clock();
        check_retire(1'b1, 5'd0, data, pc + 32'd4, 1'b0);
        step_clock();
        check_reg(5'd0, 32'd0);
    endtask

    task automatic store_load_test();
        logic [31:0] base;
        for (int w = 0; w < 4; w++) begin
            store_to(f3_word, 32'(w * 4), next_rand());
        end
        for (int w = 0; w < 4; w++) begin
            store_to(f3_half, 32'(w * 4 + 2 * (w % 2)), next_rand());
        end
        for (int w = 0; w < 4; w++) begin
            store_to(f3_byte, 32'(w * 4 + w), next_rand());
        end
        for (int w = 0; w < 4; w++) begin
            base = 32'(w * 4);
            load_check(f3_word, base, 5'd20);
            for (int h = 0; h < 2; h++) begin
                load_check(f3_half, base + 32'(2 * h), 5'd21);
                load_check(f3_half_u, base + 32'(2 * h), 5'd22);
            end
            for (int b = 0; b < 4; b++) begin
                load_check(f3_byte, base + 32'(b), 5'd23);
                load_check(f3_byte_u, base + 32'(b), 5'd24);
            end
        end
    endtask

    task automatic pc_output_test();
        logic [31:0] pc;
        logic [31:0] data;
        pc = next_rand() & 32'hffff_fffc;
        issue(make_instr(store, f3_word, 1'b0, 5'd7, 32'h300, next_rand(), pc, 1'b1));
        step_clock();
        check_retire(1'b0, 5'd7, 32'd0, pc + 32'd4, 1'b1);
        pc = next_rand() & 32'hffff_fffc;
        issue(make_instr(branch, f3_byte, 1'b0, 5'd8, next_rand(), 32'd0, pc, 1'b1));
        step_clock();
        check_retire(1'b0, 5'd8, 32'd0, pc + 32'd4, 1'b1);
        // PC wraps to zero
        data = next_rand();
        issue(make_instr(itype, f3_word, 1'b1, 5'd9, data, 32'd0, 32'hffff_fffc, 1'b0));
        step_clock();
        check_retire(1'b1, 5'd9, data, 32'd0, 1'b0);
    endtask

    task automatic stall_test();
        logic [31:0] d_load;
        logic [31:0] d_keep;
        logic [31:0] d_alu;
        logic [31:0] pc_l;
        logic [31:0] pc_a;
        d_load = next_rand();
        d_keep = next_rand();
        d_alu = next_rand();
        pc_l = next_rand() & 32'hffff_fffc;
        pc_a = next_rand() & 32'hffff_fffc;
        store_to(f3_word, 32'h40, d_load);
        store_to(f3_word, 32'h44, d_keep);
        ex_in = make_instr(load, f3_word, 1'b1, 5'd10, 32'h40, 32'd0, pc_l, 1'b1);
        step_clock();
        ex_in = make_instr(itype, f3_word, 1'b1, 5'd11, d_alu, 32'd0, pc_a, 1'b0);
        step_clock();
        check_retire(1'b1, 5'd10, d_load, pc_l + 32'd4, 1'b1);
        // Store waits on ex_in while stalled
        stall = 1'b1;
        ex_in = make_instr(store, f3_word, 1'b0, 5'd0, 32'h44, ~d_keep, pc_a, 1'b0);
        for (int c = 0; c < 3; c++) begin
            step_clock();
            check_retire(1'b1, 5'd10, 32'd0, pc_l + 32'd4, 1'b1);
        end
        stall = 1'b0;
        ex_in = '0;
        step_clock();
        check_retire(1'b1, 5'd11, d_alu, pc_a + 32'd4, 1'b0);
        step_clock();
        check_value("retire_ce", 32'(retire_ce), 32'd0);
        check_reg(5'd11, d_alu);
        load_check(f3_word, 32'h44, 5'd15);
    endtask

    task automatic flush_test();
        logic [31:0] pc;
        logic [31:0] d_z;
        pc = next_rand() & 32'hffff_fffc;
        ex_in = make_instr(itype, f3_word, 1'b1, 5'd12, next_rand(), 32'd0, pc, 1'b0);
        step_clock();
        ex_in = make_instr(rtype, f3_word, 1'b1, 5'd13, next_rand(), 32'd0, pc + 32'd4, 1'b0);
        flush = 1'b1;
        step_clock();
        flush = 1'b0;
        ex_in = '0;
        check_value("flush_out", 32'(flush_out), 32'd1);
        check_value("retire_ce", 32'(retire_ce), 32'd0);
        check_value("rd_write.we", 32'(rd_write.we), 32'd0);
        step_clock();
        check_value("flush_out", 32'(flush_out), 32'd0);
        check_value("retire_ce", 32'(retire_ce), 32'd0);
        step_clock();
        check_reg(5'd12, 32'd0);
        check_reg(5'd13, 32'd0);
        d_z = next_rand();
        issue(make_instr(rtype, f3_word, 1'b1, 5'd14, d_z, 32'd0, pc, 1'b0));
        step_clock();
        check_retire(1'b1, 5'd14, d_z, pc + 32'd4, 1'b0);
        step_clock();
        check_reg(5'd14, d_z);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        rng_state = 32'd85116;
        wb_clk = 1'b0;
        wb_rst = 1'b0;
        ex_in = '0;
        stall = 1'b0;
        flush = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge wb_clk);
        #1;
        wb_rst = 1'b1;
        step_clock();
        check_value("retire_ce", 32'(retire_ce), 32'd0);
        check_value("rd_write.we", 32'(rd_write.we), 32'd0);
        check_value("change_pc", 32'(change_pc), 32'd0);
        check_value("flush_out", 32'(flush_out), 32'd0);
        alu_retire_test();
        store_load_test();
        pc_output_test();
        stall_test();
        flush_test();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut0.asserts0.failures);
        if (errors == 0 && dut0.asserts0.failures == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
